// File: common/fetch_params.svh
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// Width of a fetch address on the OBI A channel
`define FETCH_ADDR_W 32

// Width of one instruction word returned on the R channel
`define FETCH_DATA_W 32

// Number of fetch buffer entries
// The prefetcher starts out with this many credits
`define FETCH_BUF_DEPTH 4

// First word fetched after reset is released
`define FETCH_BOOT_ADDR 32'h0000_0080

`endif

// File: common/obi_pkg.sv
`include "fetch_params.svh"

// Types seen on the OBI side of the fetch path
package obi_pkg;

  // Word-aligned fetch address, the low two bits are always zero
  typedef logic [`FETCH_ADDR_W-1:0] obi_addr_t;

  // One instruction word as returned by memory
  typedef logic [`FETCH_DATA_W-1:0] obi_data_t;

  // Adapter A channel states
  // TRANSPARENT passes the transaction request straight through
  // REGISTERED drives the A channel from the held copy until grant
  typedef enum logic
  {
    TRANSPARENT = 1'b0,
    REGISTERED  = 1'b1
  } obi_if_state_e;

endpackage

// File: common/fetch_pkg.sv
`include "fetch_params.svh"

// Types used between the prefetcher and the fetch buffer
package fetch_pkg;

  // Holds 0 up to FETCH_BUF_DEPTH inclusive
  // Used for credits, outstanding responses and credit returns
  typedef logic [$clog2(`FETCH_BUF_DEPTH+1)-1:0] fetch_credit_t;

  // Index into the fetch buffer storage
  typedef logic [$clog2(`FETCH_BUF_DEPTH)-1:0] fetch_ptr_t;

endpackage

// File: verilog/instr_obi_adapter.sv
`timescale 1ns/10ps

module instr_obi_adapter
(
  input  logic              clk,
  input  logic              rst_n,

  // Transaction requests from the prefetcher
  input  logic              trans_valid_i,
  output logic              trans_ready_o,
  input  obi_pkg::obi_addr_t trans_addr_i,

  // Transaction responses towards the fetch buffer
  output logic              resp_valid_o,
  output obi_pkg::obi_data_t resp_rdata_o,
  output logic              resp_err_o,

  // OBI A channel
  output logic              obi_req_o,
  input  logic              obi_gnt_i,
  output obi_pkg::obi_addr_t obi_addr_o,

  // OBI R channel
  input  logic              obi_rvalid_i,
  input  obi_pkg::obi_data_t obi_rdata_i,
  input  logic              obi_err_i
);

  import obi_pkg::*;

  obi_if_state_e state_q;
  obi_if_state_e state_d;

  // Copy of the A channel address held while waiting for grant
  obi_addr_t addr_q;

  ////////////////////////////////////////////////////////////////////////////
  // R channel

  // Responses go straight on to the buffer, which can always take them
  assign resp_valid_o = obi_rvalid_i;
  assign resp_rdata_o = obi_rdata_i;
  assign resp_err_o   = obi_err_i;

  ////////////////////////////////////////////////////////////////////////////
  // A channel state machine

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      TRANSPARENT:
      begin
        // A request that is not granted right away must stay stable
        if (obi_req_o && !obi_gnt_i)
        begin
          state_d = REGISTERED;
        end
      end
      REGISTERED:
      begin
        // Back to pass-through in the cycle after grant
        if (obi_gnt_i)
        begin
          state_d = TRANSPARENT;
        end
      end
      default:
      begin
        state_d = TRANSPARENT;
      end
    endcase
  end

  // In TRANSPARENT the A channel follows the request in the same cycle
  // In REGISTERED req never drops and the address comes from the copy
  always_comb
  begin
    if (state_q == TRANSPARENT)
    begin
      obi_req_o  = trans_valid_i;
      obi_addr_o = trans_addr_i;
    end
    else
    begin
      obi_req_o  = 1'b1;
      obi_addr_o = addr_q;
    end
  end

  // A new request is only taken once the previous one has been granted
  // The number of outstanding transfers is bounded by the prefetcher credits
  assign trans_ready_o = (state_q == TRANSPARENT);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q <= TRANSPARENT;
    end
    else
    begin
      state_q <= state_d;
    end
  end

  // Capture the address on the way into REGISTERED
  always_ff @(posedge clk)
  begin
    if ((state_q == TRANSPARENT) && (state_d == REGISTERED))
    begin
      addr_q <= obi_addr_o;
    end
  end

endmodule

// File: fetch/prefetch_ctrl.sv
`timescale 1ns/10ps

`include "fetch_params.svh"

module prefetch_ctrl
(
  input  logic                    clk,
  input  logic                    rst_n,

  // Redirect from the core
  input  logic                    branch_i,
  input  obi_pkg::obi_addr_t      branch_addr_i,

  // Transaction requests towards the OBI adapter
  output logic                    trans_valid_o,
  input  logic                    trans_ready_i,
  output obi_pkg::obi_addr_t      trans_addr_o,

  // Bookkeeping towards the fetch buffer
  output logic                    issue_o,
  output logic                    flush_o,
  input  fetch_pkg::fetch_credit_t credit_ret_i
);

  import obi_pkg::*;
  import fetch_pkg::*;

  // Address offered next on the transaction link
  obi_addr_t     addr_q;

  // One credit per free buffer slot not yet claimed by a transfer
  fetch_credit_t credits_q;
  fetch_credit_t credits_d;

  // Low during reset and for the first cycle after it
  logic          run_q;

  logic          accept;

  ////////////////////////////////////////////////////////////////////////////
  // Request offer

  // No offer without a credit, and none in a branch cycle
  // The address register is about to be replaced in that cycle
  assign trans_valid_o = run_q && (credits_q != '0) && !branch_i;
  assign trans_addr_o  = addr_q;

  assign accept  = trans_valid_o && trans_ready_i;

  // Buffer counts one outstanding response per accepted transfer
  assign issue_o = accept;

  // Everything in flight or buffered belongs to the old stream
  assign flush_o = branch_i;

  ////////////////////////////////////////////////////////////////////////////
  // Credit counter

  always_comb
  begin
    credits_d = credits_q + credit_ret_i;
    if (accept)
    begin
      credits_d = credits_d - fetch_credit_t'(1);
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      run_q     <= 1'b0;
      credits_q <= fetch_credit_t'(`FETCH_BUF_DEPTH);
      addr_q    <= `FETCH_BOOT_ADDR;
    end
    else
    begin
      run_q     <= 1'b1;
      credits_q <= credits_d;
      // Branch target is forced to a word boundary
      if (branch_i)
      begin
        addr_q <= {branch_addr_i[`FETCH_ADDR_W-1:2], 2'b00};
      end
      else if (accept)
      begin
        addr_q <= addr_q + obi_addr_t'(4);
      end
    end
  end

endmodule

// File: fetch/fetch_buffer.sv
`timescale 1ns/10ps

`include "fetch_params.svh"

module fetch_buffer
(
  input  logic                     clk,
  input  logic                     rst_n,

  // From the prefetcher
  input  logic                     issue_i,
  input  logic                     flush_i,

  // Responses from the OBI adapter
  input  logic                     resp_valid_i,
  input  obi_pkg::obi_data_t       resp_rdata_i,
  input  logic                     resp_err_i,

  // Towards the decode stage
  output logic                     instr_valid_o,
  input  logic                     instr_ready_i,
  output obi_pkg::obi_data_t       instr_rdata_o,
  output logic                     instr_err_o,

  // Credits freed this cycle
  output fetch_pkg::fetch_credit_t credit_ret_o
);

  import obi_pkg::*;
  import fetch_pkg::*;

  // Entry storage
  obi_data_t     data_q [`FETCH_BUF_DEPTH];
  logic          err_q  [`FETCH_BUF_DEPTH];

  fetch_ptr_t    wr_ptr_q;
  fetch_ptr_t    rd_ptr_q;

  // Valid entries, responses still due, and stale responses to drop
  fetch_credit_t count_q;
  fetch_credit_t count_d;
  fetch_credit_t outst_q;
  fetch_credit_t outst_d;
  fetch_credit_t discard_q;
  fetch_credit_t discard_d;

  logic          push;
  logic          pop;
  logic          drop;

  assign instr_valid_o = (count_q != '0);
  assign instr_rdata_o = data_q[rd_ptr_q];
  assign instr_err_o   = err_q[rd_ptr_q];

  assign pop  = instr_valid_o && instr_ready_i;
  // A response in the flush cycle is stale as well
  assign drop = resp_valid_i && (flush_i || (discard_q != '0));
  assign push = resp_valid_i && !drop;

  ////////////////////////////////////////////////////////////////////////////
  // Counters and credit return

  always_comb
  begin
    outst_d = outst_q + fetch_credit_t'(issue_i) - fetch_credit_t'(resp_valid_i);
    if (flush_i)
    begin
      // Every response still due after this cycle is dropped on arrival
      count_d      = '0;
      discard_d    = outst_q - fetch_credit_t'(resp_valid_i);
      credit_ret_o = count_q + fetch_credit_t'(drop);
    end
    else
    begin
      count_d      = count_q + fetch_credit_t'(push) - fetch_credit_t'(pop);
      discard_d    = discard_q - fetch_credit_t'(drop);
      credit_ret_o = fetch_credit_t'(pop) + fetch_credit_t'(drop);
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
      count_q   <= '0;
      outst_q   <= '0;
      discard_q <= '0;
    end
    else
    begin
      count_q   <= count_d;
      outst_q   <= outst_d;
      discard_q <= discard_d;
      if (flush_i)
      begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
      end
      else
      begin
        // Pointers wrap at the power-of-two depth
        if (push)
        begin
          wr_ptr_q <= wr_ptr_q + fetch_ptr_t'(1);
        end
        if (pop)
        begin
          rd_ptr_q <= rd_ptr_q + fetch_ptr_t'(1);
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (push)
    begin
      data_q[wr_ptr_q] <= resp_rdata_i;
      err_q[wr_ptr_q]  <= resp_err_i;
    end
  end

endmodule

// File: verilog/instr_fetch_top.sv
`timescale 1ns/10ps

module instr_fetch_top
(
  input  logic               clk,
  input  logic               rst_n,

  // Redirect from the core
  input  logic               branch_i,
  input  obi_pkg::obi_addr_t branch_addr_i,

  // Instruction stream towards decode
  output logic               instr_valid_o,
  input  logic               instr_ready_i,
  output obi_pkg::obi_data_t instr_rdata_o,
  output logic               instr_err_o,

  // OBI instruction port
  output logic               obi_req_o,
  input  logic               obi_gnt_i,
  output obi_pkg::obi_addr_t obi_addr_o,
  input  logic               obi_rvalid_i,
  input  obi_pkg::obi_data_t obi_rdata_i,
  input  logic               obi_err_i
);

  import obi_pkg::*;
  import fetch_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Internal links

  // Prefetcher to adapter
  logic          trans_valid;
  logic          trans_ready;
  obi_addr_t     trans_addr;

  // Adapter to buffer, no back-pressure
  logic          resp_valid;
  obi_data_t     resp_rdata;
  logic          resp_err;

  // Prefetcher and buffer bookkeeping
  logic          issue;
  logic          flush;
  fetch_credit_t credit_ret;

  prefetch_ctrl u_prefetch_ctrl
  (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .trans_valid_o (trans_valid),
    .trans_ready_i (trans_ready),
    .trans_addr_o  (trans_addr),
    .issue_o       (issue),
    .flush_o       (flush),
    .credit_ret_i  (credit_ret)
  );

  instr_obi_adapter u_instr_obi_adapter
  (
    .clk           (clk),
    .rst_n         (rst_n),
    .trans_valid_i (trans_valid),
    .trans_ready_o (trans_ready),
    .trans_addr_i  (trans_addr),
    .resp_valid_o  (resp_valid),
    .resp_rdata_o  (resp_rdata),
    .resp_err_o    (resp_err),
    .obi_req_o     (obi_req_o),
    .obi_gnt_i     (obi_gnt_i),
    .obi_addr_o    (obi_addr_o),
    .obi_rvalid_i  (obi_rvalid_i),
    .obi_rdata_i   (obi_rdata_i),
    .obi_err_i     (obi_err_i)
  );

  fetch_buffer u_fetch_buffer
  (
    .clk           (clk),
    .rst_n         (rst_n),
    .issue_i       (issue),
    .flush_i       (flush),
    .resp_valid_i  (resp_valid),
    .resp_rdata_i  (resp_rdata),
    .resp_err_i    (resp_err),
    .instr_valid_o (instr_valid_o),
    .instr_ready_i (instr_ready_i),
    .instr_rdata_o (instr_rdata_o),
    .instr_err_o   (instr_err_o),
    .credit_ret_o  (credit_ret)
  );

endmodule

// File: test/obi_mem_model.sv
`timescale 1ns/10ps

// OBI instruction memory with random grant stalls and in-order responses
module obi_mem_model
(
  input  logic               clk,
  input  logic               rst_n,

  // Per-cycle draws from the testbench random generator
  input  logic [1:0]         stall_i,
  input  logic [1:0]         lat_i,

  // OBI A channel
  input  logic               req_i,
  output logic               gnt_o,
  input  obi_pkg::obi_addr_t addr_i,

  // OBI R channel
  output logic               rvalid_o,
  output obi_pkg::obi_data_t rdata_o,
  output logic               err_o
);

  import obi_pkg::*;

  localparam obi_data_t DATA_MASK = 32'h5A5A_0000;
  localparam obi_addr_t ERR_BASE  = 32'hF000_0000;

  // Cycles left before the pending request is granted
  logic [1:0] stall_q;

  // Granted requests waiting for their response, oldest first
  obi_addr_t  addr_q [$];
  int         due_q  [$];

  int         cyc;
  int         last_due;
  int         due;
  obi_addr_t  raddr;

  assign gnt_o = req_i && (stall_q == 2'd0);

  always @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      stall_q  <= 2'd0;
      rvalid_o <= 1'b0;
      rdata_o  <= '0;
      err_o    <= 1'b0;
      addr_q.delete();
      due_q.delete();
      cyc      = 0;
      last_due = 0;
    end
    else
    begin
      // A new stall length is drawn after every grant
      if (req_i && gnt_o)
      begin
        stall_q <= stall_i;
        due = cyc + int'(lat_i);
        // Responses never overtake each other, so dues strictly increase
        if (due <= last_due)
        begin
          due = last_due + 1;
        end
        last_due = due;
        addr_q.push_back(addr_i);
        due_q.push_back(due);
      end
      else if (req_i)
      begin
        stall_q <= stall_q - 2'd1;
      end

      // At most one response is due in any cycle
      rvalid_o <= 1'b0;
      if ((due_q.size() != 0) && (due_q[0] <= cyc + 1))
      begin
        raddr = addr_q.pop_front();
        void'(due_q.pop_front());
        rvalid_o <= 1'b1;
        rdata_o  <= raddr ^ DATA_MASK;
        err_o    <= (raddr >= ERR_BASE);
      end
      cyc = cyc + 1;
    end
  end

endmodule

// File: test/tb_instr_fetch.sv
`timescale 1ns/10ps

`include "fetch_params.svh"

module tb_instr_fetch;

  import obi_pkg::*;

  localparam int TIMEOUT = 2000;

  logic        clk;
  logic        rst_n;
  logic        branch_i;
  obi_addr_t   branch_addr_i;
  logic        instr_ready_i;
  logic        instr_valid;
  obi_data_t   instr_rdata;
  logic        instr_err;

  logic        obi_req;
  logic        obi_gnt;
  obi_addr_t   obi_addr;
  logic        obi_rvalid;
  obi_data_t   obi_rdata;
  logic        obi_err;

  logic [1:0]  mem_stall;
  logic [1:0]  mem_lat;
  logic [31:0] rnd = 32'h6431;

  // Error counts by kind
  int          data_errs = 0;
  int          err_errs = 0;
  int          bus_errs = 0;
  int          other_errs = 0;

  // Monitor state, updated only on the rising edge
  obi_addr_t   exp_addr;
  obi_addr_t   exp_grant;
  obi_addr_t   held_addr;
  logic        stalled_q;
  int          consumed;
  int          pending;
  int          live;
  int          stall_seen;

  instr_fetch_top dut0
  (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .instr_valid_o (instr_valid),
    .instr_ready_i (instr_ready_i),
    .instr_rdata_o (instr_rdata),
    .instr_err_o   (instr_err),
    .obi_req_o     (obi_req),
    .obi_gnt_i     (obi_gnt),
    .obi_addr_o    (obi_addr),
    .obi_rvalid_i  (obi_rvalid),
    .obi_rdata_i   (obi_rdata),
    .obi_err_i     (obi_err)
  );

  obi_mem_model u_mem
  (
    .clk      (clk),
    .rst_n    (rst_n),
    .stall_i  (mem_stall),
    .lat_i    (mem_lat),
    .req_i    (obi_req),
    .gnt_o    (obi_gnt),
    .addr_i   (obi_addr),
    .rvalid_o (obi_rvalid),
    .rdata_o  (obi_rdata),
    .err_o    (obi_err)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Grant stall of 0 to 3 cycles and response latency of 1 to 3 cycles
  always @(posedge clk)
  begin
    rnd = lcg_next(rnd);
    mem_stall <= rnd[17:16];
    mem_lat   <= (rnd[25:24] == 2'd3) ? 2'd1 : rnd[25:24] + 2'd1;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks

  task automatic check_data(input string name, input obi_data_t got, input obi_data_t exp);
    if (got !== exp)
    begin
      $display("FAIL at %0t: %s got %h expected %h", $time, name, got, exp);
      data_errs++;
    end
  endtask

  task automatic check_err(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("FAIL at %0t: %s got %b expected %b", $time, name, got, exp);
      err_errs++;
    end
  endtask

  task automatic check_addr(input string name, input obi_addr_t got, input obi_addr_t exp);
    if (got !== exp)
    begin
      $display("FAIL at %0t: %s got %h expected %h", $time, name, got, exp);
      bus_errs++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("FAIL at %0t: %s got %b expected %b", $time, name, got, exp);
      bus_errs++;
    end
  endtask

  task automatic print_summary();
    $display("Summary: %0d data, %0d err, %0d bus, %0d other errors",
             data_errs, err_errs, bus_errs, other_errs);
  endtask

  task automatic timeout_abort(input string what);
    $display("Timeout: %s", what);
    other_errs++;
    print_summary();
    $display("CHECKS FAILED");
    $finish;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Bus and stream monitor

  always @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      exp_addr   = `FETCH_BOOT_ADDR;
      exp_grant  = `FETCH_BOOT_ADDR;
      held_addr  = '0;
      stalled_q  = 1'b0;
      consumed   = 0;
      pending    = 0;
      live       = 0;
      stall_seen = 0;
    end
    else
    begin
      // A request left waiting in the last cycle must not have moved
      if (stalled_q)
      begin
        check_flag("obi_req_o", obi_req, 1'b1);
        check_addr("obi_addr_o", obi_addr, held_addr);
      end
      stalled_q = obi_req && !obi_gnt;
      held_addr = obi_addr;
      if (stalled_q)
      begin
        stall_seen++;
      end
      pending = pending + int'(obi_req && obi_gnt) - int'(obi_rvalid);

      // The consumer holds ready low in a branch cycle, so nothing pops there
      if (branch_i)
      begin
        exp_addr  = {branch_addr_i[`FETCH_ADDR_W-1:2], 2'b00};
        exp_grant = exp_addr;
        live      = 0;
      end
      else
      begin
        // Only grants of the current stream count as live words
        if (obi_req && obi_gnt && (obi_addr == exp_grant))
        begin
          live++;
          exp_grant = exp_grant + 32'd4;
        end
        if (instr_valid && instr_ready_i)
        begin
          check_data("instr_rdata_o", instr_rdata, exp_addr ^ 32'h5A5A_0000);
          check_err("instr_err_o", instr_err, exp_addr >= 32'hF000_0000);
          exp_addr = exp_addr + 32'd4;
          consumed++;
          live--;
        end
        if (live > `FETCH_BUF_DEPTH)
        begin
          $display("More words granted than the fetch buffer can hold at %0t", $time);
          other_errs++;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers

  task automatic wait_consumed(input int n);
    int target;
    int cycles;
    @(negedge clk);
    target = consumed + n;
    cycles = 0;
    while ((consumed < target) && (cycles < TIMEOUT))
    begin
      @(negedge clk);
      cycles++;
    end
    if (consumed < target)
    begin
      timeout_abort("instructions stopped arriving at the consumer");
    end
  endtask

  // Ready is dropped in the branch cycle so no old word is taken there
  task automatic take_branch(input obi_addr_t target);
    @(posedge clk);
    branch_i      <= 1'b1;
    branch_addr_i <= target;
    instr_ready_i <= 1'b0;
    @(posedge clk);
    branch_i      <= 1'b0;
    instr_ready_i <= 1'b1;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests

  task automatic boot_fetch();
    wait_consumed(16);
  endtask

  task automatic back_pressure();
    @(posedge clk);
    instr_ready_i <= 1'b0;
    repeat (40) @(posedge clk);
    // Buffer full and credits used up, so the port has gone quiet
    @(negedge clk);
    check_flag("obi_req_o", obi_req, 1'b0);
    check_flag("instr_valid_o", instr_valid, 1'b1);
    @(posedge clk);
    instr_ready_i <= 1'b1;
    wait_consumed(12);
  endtask

  task automatic addr_stability();
    int seen_before;
    @(negedge clk);
    seen_before = stall_seen;
    wait_consumed(24);
    if (stall_seen == seen_before)
    begin
      $display("No grant stall happened on the OBI port during the stability test");
      other_errs++;
    end
  endtask

  task automatic redirect();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while ((pending == 0) && (cycles < TIMEOUT))
    begin
      @(negedge clk);
      cycles++;
    end
    if (pending == 0)
    begin
      timeout_abort("no OBI response was ever outstanding");
    end
    take_branch(32'h0000_1000);
    wait_consumed(8);
  endtask

  task automatic error_path();
    // Misaligned target, the low bits are dropped by the prefetcher
    take_branch(32'hF000_0102);
    wait_consumed(6);
    take_branch(32'h0000_2000);
    wait_consumed(6);
  endtask

  initial
  begin
    rst_n         = 1'b0;
    branch_i      = 1'b0;
    branch_addr_i = '0;
    instr_ready_i = 1'b1;
    mem_stall     = 2'd0;
    mem_lat       = 2'd1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_flag("obi_req_o", obi_req, 1'b0);
    check_flag("instr_valid_o", instr_valid, 1'b0);
    @(posedge clk);
    rst_n <= 1'b1;

    boot_fetch();
    back_pressure();
    addr_stability();
    redirect();
    error_path();

    print_summary();
    if ((data_errs + err_errs + bus_errs + other_errs) == 0)
    begin
      $display("ALL CHECKS PASSED");
    end
    else
    begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// File: build.f
+incdir+common
common/obi_pkg.sv
common/fetch_pkg.sv
verilog/instr_obi_adapter.sv
fetch/prefetch_ctrl.sv
fetch/fetch_buffer.sv
verilog/instr_fetch_top.sv
test/obi_mem_model.sv
test/tb_instr_fetch.sv

// File: run_sim.sh
#!/bin/sh
# Builds the fetch front end testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f build.f --top-module tb_instr_fetch -Mdir obj_dir

result=$(./obj_dir/Vtb_instr_fetch)
echo "$result"

if echo "$result" | grep -q "ALL CHECKS PASSED"; then
  exit 0
fi
echo "Simulation reported failures"
exit 1
